/* Bender.yml */
package:
  name: freeze_cart

sources:
  - hdl/cart_pkg.sv
  - hdl/cart_bus_if.sv
  - hdl/freeze_timer.sv
  - hdl/freeze_fsm.sv
  - hdl/cart_decode.sv
  - hdl/cart_ram.sv
  - hdl/cart_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/cart_assertions.sv
      - verification/cart_tb.sv

/* compile.f */
hdl/cart_pkg.sv
hdl/cart_bus_if.sv
hdl/freeze_timer.sv
hdl/freeze_fsm.sv
hdl/cart_decode.sv
hdl/cart_ram.sv
hdl/cart_top.sv
verification/tb_clock.sv
verification/cart_assertions.sv
verification/cart_tb.sv

/* hdl/cart_bus_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decoded CPU bus cycle between the inner
// cartridge blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface cart_bus_if;

  // word address, bits 23:1 of the CPU address
  cart_pkg::cpu_addr_u addr;
  // address strobe, active low as on the CPU pin
  logic                as_n;
  logic                rd;
  // upper and lower byte write strobes
  logic                hwr;
  logic                lwr;
  logic [15:0]         wdata;
  // cartridge select, the only signal the decoder drives
  logic                sel;

  modport decoder (output sel, input addr, as_n, rd, hwr, lwr, wdata);

  modport mem (input addr, hwr, lwr, wdata, sel);

  modport ctrl (input addr, as_n, rd, sel);

endinterface

/* hdl/cart_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cartridge select, vector override and
// registered output data mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cart_decode (
  input  logic        clk,
  input  logic        cpu_rst,
  cart_bus_if.decoder bus,
  input  logic        dbr,
  input  logic        overlay_active,
  input  logic [15:0] rdata,
  output logic        sel_cart,
  output logic        ovr,
  output logic [15:0] cart_data
);

  // source of the word returned one cycle after a read
  logic        ovr_q;
  logic        ram_q;
  logic [15:0] vec_q;

  // cartridge view, the bank field selects the monitor RAM window
  // the chip bus has the cycle when dbr is high
  assign bus.sel  = !dbr && (bus.addr.cart.bank == cart_pkg::cart_base);
  assign sel_cart = bus.sel;

  // vector view, only reads of 0x7C and 0x7E while the overlay is up
  assign ovr = overlay_active && !dbr && bus.rd &&
               (bus.addr.vec.page == cart_pkg::nmi_vec_page);

  always_ff @(posedge clk) begin
    if (cpu_rst) begin
      ovr_q <= 1'b0;
      ram_q <= 1'b0;
    end else begin
      ovr_q <= ovr;
      ram_q <= bus.sel && bus.rd;
    end
  end

  // the vector word is picked in the read cycle so it meets the RAM word
  always_ff @(posedge clk) begin
    vec_q <= bus.addr.vec.word_sel ? cart_pkg::nmi_vec_lo : cart_pkg::nmi_vec_hi;
  end

  // ovr and sel never overlap, the vector page lies in bank 0
  assign cart_data = ovr_q ? vec_q :
                     ram_q ? rdata : 16'h0000;

endmodule

/* hdl/cart_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// freeze cartridge shared constants, FSM
// state type and the CPU address union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cart_pkg;

  // address bits 23:19 of the monitor RAM window 0xA00000 to 0xA7FFFF
  localparam logic [4:0] cart_base = 5'b10100;

  // level 7 autovector words, the CPU ends up at 0xA0000C
  localparam logic [15:0] nmi_vec_hi = 16'h00A0;
  localparam logic [15:0] nmi_vec_lo = 16'h000C;

  // address bits 23:2 shared by the vector words at 0x00007C and 0x00007E
  localparam logic [21:0] nmi_vec_page = 22'h00001F;

  // freeze controller states
  // irq_pending holds the interrupt, overlay swaps in the vector words
  typedef enum logic [1:0] {
    idle        = 2'd0,
    irq_pending = 2'd1,
    overlay     = 2'd2
  } fsm_state_t;

  // cartridge view of the word address
  // bank is compared against cart_base, offset indexes the RAM
  typedef struct packed {
    logic [4:0]  bank;
    logic [17:0] offset;
  } cart_view_t;

  // vector view of the word address
  // page picks the autovector long word, word_sel picks its half
  typedef struct packed {
    logic [21:0] page;
    logic        word_sel;
  } vec_view_t;

  // CPU word address, bits 23:1, read through either view
  typedef union packed {
    cart_view_t cart;
    vec_view_t  vec;
  } cpu_addr_u;

endpackage

/* hdl/cart_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// monitor RAM bank, byte writes and
// registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cart_ram #(
  parameter int RAM_AW = 12
) (
  input  logic        clk,
  cart_bus_if.mem     bus,
  output logic [15:0] rdata
);

  localparam int DEPTH = 2 ** RAM_AW;

  logic [15:0]       mem [DEPTH];
  logic [RAM_AW-1:0] idx;

  // the array repeats over the whole 512 KB window
  // so only the low offset bits are decoded
  assign idx = bus.addr.cart.offset[RAM_AW-1:0];

  // each strobe writes its own byte lane
  always_ff @(posedge clk) begin
    if (bus.sel && bus.hwr) begin
      mem[idx][15:8] <= bus.wdata[15:8];
    end
    if (bus.sel && bus.lwr) begin
      mem[idx][7:0] <= bus.wdata[7:0];
    end
  end

  // read every cycle, a write in the same cycle returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem[idx];
  end

endmodule

/* hdl/cart_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// freeze cartridge top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cart_top #(
  parameter int FREEZE_HOLD = 4,
  parameter int RAM_AW      = 12
) (
  input  logic        clk,
  input  logic        cpu_rst,
  // CPU word address, bits 23:1
  input  logic [23:1] cpu_address,
  input  logic        as_n,
  input  logic        rd,
  input  logic        hwr,
  input  logic        lwr,
  input  logic [15:0] wdata,
  // chip bus request, the cartridge keeps off the bus while high
  input  logic        dbr,
  input  logic        freeze,
  output logic [15:0] cart_data,
  output logic        int7,
  output logic        sel_cart,
  output logic        ovr
);

  logic        press;
  logic        overlay_active;
  logic [15:0] rdata;

  // the CPU cycle is gathered once and shared by the inner blocks
  cart_bus_if bus ();

  assign bus.addr  = cpu_address;
  assign bus.as_n  = as_n;
  assign bus.rd    = rd;
  assign bus.hwr   = hwr;
  assign bus.lwr   = lwr;
  assign bus.wdata = wdata;

  freeze_timer #(
    .FREEZE_HOLD(FREEZE_HOLD)
  ) u_freeze_timer (
    .clk    (clk),
    .cpu_rst(cpu_rst),
    .freeze (freeze),
    .press  (press)
  );

  freeze_fsm u_freeze_fsm (
    .clk           (clk),
    .cpu_rst       (cpu_rst),
    .press         (press),
    .bus           (bus.ctrl),
    .int7          (int7),
    .overlay_active(overlay_active)
  );

  cart_decode u_cart_decode (
    .clk           (clk),
    .cpu_rst       (cpu_rst),
    .bus           (bus.decoder),
    .dbr           (dbr),
    .overlay_active(overlay_active),
    .rdata         (rdata),
    .sel_cart      (sel_cart),
    .ovr           (ovr),
    .cart_data     (cart_data)
  );

  cart_ram #(
    .RAM_AW(RAM_AW)
  ) u_cart_ram (
    .clk  (clk),
    .bus  (bus.mem),
    .rdata(rdata)
  );

endmodule

/* hdl/freeze_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// freeze controller: level 7 request,
// acknowledge and vector overlay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module freeze_fsm (
  input  logic        clk,
  input  logic        cpu_rst,
  input  logic        press,
  cart_bus_if.ctrl    bus,
  output logic        int7,
  output logic        overlay_active
);

  cart_pkg::fsm_state_t state;

  logic int_ack;
  logic cart_read;

  // the interrupt acknowledge cycle drives every address line high
  // with the strobe asserted, the CPU reads the vector number there
  assign int_ack = (&bus.addr) && !bus.as_n && bus.rd;

  // the first read from the cartridge window means the monitor is running
  assign cart_read = bus.rd && bus.sel;

  always_ff @(posedge clk) begin
    if (cpu_rst) begin
      state <= cart_pkg::idle;
    end else begin
      case (state)
        cart_pkg::idle: begin
          if (press) begin
            state <= cart_pkg::irq_pending;
          end
        end
        cart_pkg::irq_pending: begin
          // further presses are dropped until the overlay is released
          if (int_ack) begin
            state <= cart_pkg::overlay;
          end
        end
        cart_pkg::overlay: begin
          if (cart_read) begin
            state <= cart_pkg::idle;
          end
        end
        default: begin
          // unused encoding, fall back to idle
          state <= cart_pkg::idle;
        end
      endcase
    end
  end

  // both outputs come straight from the state register
  assign int7           = (state == cart_pkg::irq_pending);
  assign overlay_active = (state == cart_pkg::overlay);

endmodule

/* hdl/freeze_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// freeze button debounce and press pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module freeze_timer #(
  parameter int FREEZE_HOLD = 4
) (
  input  logic clk,
  input  logic cpu_rst,
  input  logic freeze,
  output logic press
);

  // the counter only has to reach FREEZE_HOLD and then sits there
  localparam int CW = $clog2(FREEZE_HOLD + 1);
  localparam logic [CW-1:0] HOLD = CW'(FREEZE_HOLD);

  logic [CW-1:0] cnt;
  // set once the current press has been reported
  logic          fired;
  logic          hold_met;

  assign hold_met = (cnt == HOLD);

  always_ff @(posedge clk) begin
    if (cpu_rst) begin
      cnt   <= '0;
      fired <= 1'b0;
      press <= 1'b0;
    end else begin
      // one pulse in the cycle after the count saturates
      press <= hold_met && !fired;
      // any low sample restarts the count and re-arms the pulse
      if (!freeze) begin
        cnt   <= '0;
        fired <= 1'b0;
      end else begin
        if (!hold_met) begin
          cnt <= cnt + 1'b1;
        end
        if (hold_met) begin
          fired <= 1'b1;
        end
      end
    end
  end

endmodule

/* verification/cart_assertions.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the freeze FSM
// outputs and the cartridge decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cart_assertions (
  input logic clk,
  input logic cpu_rst,
  input logic int7,
  input logic overlay_active,
  input logic sel_cart,
  input logic ovr
);

  // the request and the overlay are two separate FSM states
  a_int7_overlay: assert property (@(posedge clk) disable iff (cpu_rst)
    !(int7 && overlay_active))
    else $error("int7 and overlay_active are high in the same cycle");

  // the vector page lies in bank 0 so the override never meets a cart select
  a_ovr_sel: assert property (@(posedge clk) disable iff (cpu_rst)
    ovr |-> !sel_cart)
    else $error("ovr and sel_cart are high in the same cycle");

  // a reset edge leaves the FSM in idle
  a_rst_int7: assert property (@(posedge clk) cpu_rst |=> !int7)
    else $error("int7 is high one cycle after reset");

endmodule

/* verification/cart_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// freeze cartridge testbench with random
// bus cycles and a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cart_tb;

  localparam int FREEZE_HOLD = 4;
  localparam int RAM_AW      = 6;
  localparam int RST_CYCLES  = 8;
  localparam int N_FILL      = 2 ** RAM_AW;
  localparam int N_RAND      = 40;
  localparam int N_SHORT     = 4;
  // longest press run is the hold time plus the rise delay and a tail of idle cycles
  localparam int PRESS_CYC   = FREEZE_HOLD + 9;
  // reset, fill, three random passes, vector reads, every press and some slack
  localparam int CYCLE_LIMIT = RST_CYCLES + N_FILL + 3 * N_RAND + 20
                             + (N_SHORT + 3) * PRESS_CYC + 100;

  // model FSM states
  localparam int ST_IDLE = 0;
  localparam int ST_IRQ  = 1;
  localparam int ST_OVL  = 2;

  logic        clk;
  logic        cpu_rst;
  logic [23:1] cpu_address;
  logic        as_n;
  logic        rd;
  logic        hwr;
  logic        lwr;
  logic [15:0] wdata;
  logic        dbr;
  logic        freeze;
  logic [15:0] cart_data;
  logic        int7;
  logic        sel_cart;
  logic        ovr;

  integer      seed = 91;
  int          cycles = 0;
  int          errors = 0;
  int          test_errors;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name;
  // model FSM state, the freeze level for the next cycle and the word due after a read
  int          mstate;
  logic        freeze_lvl;
  logic [15:0] pend_data;
  logic [15:0] shadow [N_FILL];

  tb_clock #(
    .PERIOD    (20),
    .RST_CYCLES(RST_CYCLES)
  ) u_clock (
    .clk    (clk),
    .cpu_rst(cpu_rst)
  );

  cart_top #(
    .FREEZE_HOLD(FREEZE_HOLD),
    .RAM_AW     (RAM_AW)
  ) DUT (
    .clk        (clk),
    .cpu_rst    (cpu_rst),
    .cpu_address(cpu_address),
    .as_n       (as_n),
    .rd         (rd),
    .hwr        (hwr),
    .lwr        (lwr),
    .wdata      (wdata),
    .dbr        (dbr),
    .freeze     (freeze),
    .cart_data  (cart_data),
    .int7       (int7),
    .sel_cart   (sel_cart),
    .ovr        (ovr)
  );

  // overlay_active is internal to cart_top and is reached through the bind scope
  bind cart_top cart_assertions u_assertions (
    .clk           (clk),
    .cpu_rst       (cpu_rst),
    .int7          (int7),
    .overlay_active(overlay_active),
    .sel_cart      (sel_cart),
    .ovr           (ovr)
  );

  // the run is stopped once the cycle count reaches the limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic report_value(input string what, input logic [15:0] exp,
                              input logic [15:0] act);
    $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
    errors++;
    test_errors++;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  // one CPU bus cycle is driven on the rising edge and checked on the falling edge
  task automatic bus_cycle(input logic [23:1] a, input logic r, input logic hw,
                           input logic lw, input logic [15:0] wd, input logic db);
    logic exp_sel;
    logic exp_ovr;
    logic exp_int7;
    @(posedge clk);
    cpu_address <= a;
    rd          <= r;
    hwr         <= hw;
    lwr         <= lw;
    wdata       <= wd;
    dbr         <= db;
    as_n        <= !(r || hw || lw);
    freeze      <= freeze_lvl;
    @(negedge clk);
    // word registered from the previous cycle
    if (cart_data !== pend_data) report_value("cart_data", pend_data, cart_data);
    exp_sel  = !db && (a[23:19] == 5'b10100);
    exp_ovr  = (mstate == ST_OVL) && !db && r && (a[23:2] == 22'h00001F);
    exp_int7 = (mstate == ST_IRQ);
    if (sel_cart !== exp_sel) report_value("sel_cart", 16'(exp_sel), 16'(sel_cart));
    if (ovr !== exp_ovr) report_value("ovr", 16'(exp_ovr), 16'(ovr));
    if (int7 !== exp_int7) report_value("int7", 16'(exp_int7), 16'(int7));
    // the RAM returns the old word, so the read comes before the write
    if (exp_ovr) begin
      pend_data = a[1] ? 16'h000C : 16'h00A0;
    end else if (exp_sel && r) begin
      pend_data = shadow[a[RAM_AW:1]];
    end else begin
      pend_data = 16'h0000;
    end
    if (exp_sel && hw) shadow[a[RAM_AW:1]][15:8] = wd[15:8];
    if (exp_sel && lw) shadow[a[RAM_AW:1]][7:0] = wd[7:0];
    // bus driven transitions take effect on the edge that ends this cycle
    if (mstate == ST_IRQ && (&a) && r && !(r || hw || lw) == 1'b0) begin
      mstate = ST_OVL;
    end else if (mstate == ST_OVL && r && exp_sel) begin
      mstate = ST_IDLE;
    end
  endtask

  task automatic idle_cycle();
    bus_cycle(23'h0, 1'b0, 1'b0, 1'b0, 16'h0, 1'b0);
  endtask

  // random word address inside the 512 KB window where the RAM aliases
  function automatic logic [23:1] cart_addr();
    logic [17:0] off;
    off = $random(seed);
    return {5'b10100, off};
  endfunction

  // freeze is held high for len cycles and int7 is due FREEZE_HOLD + 2 cycles after the rise
  task automatic run_press(input int len, input bit rise);
    int total;
    total = ((len > FREEZE_HOLD + 2) ? len : FREEZE_HOLD + 2) + 4;
    for (int k = 0; k < total; k++) begin
      freeze_lvl = (k < len);
      if (rise && k == FREEZE_HOLD + 2) mstate = ST_IRQ;
      idle_cycle();
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [23:1] a;
    cpu_address = '0;
    as_n        = 1'b1;
    rd          = 1'b0;
    hwr         = 1'b0;
    lwr         = 1'b0;
    wdata       = '0;
    dbr         = 1'b0;
    freeze      = 1'b0;
    freeze_lvl  = 1'b0;
    mstate      = ST_IDLE;
    pend_data   = 16'h0000;
    while (cpu_rst !== 1'b0) @(posedge clk);

    start_test("ram_fill_readback");
    // full words first so no byte of the array stays unknown
    for (int i = 0; i < N_FILL; i++) begin
      a = cart_addr();
      a[RAM_AW:1] = RAM_AW'(i);
      bus_cycle(a, 1'b0, 1'b1, 1'b1, 16'($random(seed)), 1'b0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      v = $random(seed);
      bus_cycle(cart_addr(), 1'b0, v[0], v[1] || !v[0], v[31:16], 1'b0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      bus_cycle(cart_addr(), 1'b1, 1'b0, 1'b0, 16'h0, 1'b0);
    end
    idle_cycle();
    end_test();

    start_test("decode_outside");
    for (int i = 0; i < N_RAND; i++) begin
      a = $random(seed);
      // odd reads fall in the window while the chipset holds the bus
      // even reads miss the window with the bus free
      if (i[0]) begin
        a[23:19] = 5'b10100;
      end else if (a[23:19] == 5'b10100) begin
        a[23] = 1'b0;
      end
      bus_cycle(a, 1'b1, 1'b0, 1'b0, 16'h0, i[0]);
    end
    idle_cycle();
    end_test();

    start_test("freeze_debounce");
    for (int i = 0; i < N_SHORT; i++) begin
      run_press(1 + ({$random(seed)} % (FREEZE_HOLD - 1)), 1'b0);
    end
    run_press(FREEZE_HOLD + ({$random(seed)} % 4), 1'b1);
    end_test();

    start_test("ack_vector");
    bus_cycle('1, 1'b1, 1'b0, 1'b0, 16'h0, 1'b0);
    idle_cycle();
    for (int i = 0; i < 8; i++) begin
      v = $random(seed);
      bus_cycle(v[0] ? 23'h3F : 23'h3E, 1'b1, 1'b0, 1'b0, 16'h0, 1'b0);
    end
    // with the chipset on the bus the override stays off
    bus_cycle(23'h3E, 1'b1, 1'b0, 1'b0, 16'h0, 1'b1);
    idle_cycle();
    end_test();

    start_test("release_rearm");
    run_press(FREEZE_HOLD + 2, 1'b0);
    bus_cycle(cart_addr(), 1'b1, 1'b0, 1'b0, 16'h0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      bus_cycle(i[0] ? 23'h3F : 23'h3E, 1'b1, 1'b0, 1'b0, 16'h0, 1'b0);
    end
    run_press(FREEZE_HOLD + ({$random(seed)} % 4), 1'b1);
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic cpu_rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset is released on a rising edge like every other DUT input
  initial begin
    cpu_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    cpu_rst <= 1'b0;
  end

endmodule
